// ==== sources.f ====
rtl/ctrlPkg.sv
rtl/stepSequencer.sv
rtl/instrDecoder.sv
rtl/controlWordGen.sv
rtl/ctrlUnit.sv
dv/ctrlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the control unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module ctrlUnitTb -f sources.f -o ctrlUnitSim
./obj_dir/ctrlUnitSim | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== dv/ctrlUnitTb.sv ====
//**********************************************************
// Testbench for ctrlUnit; runs instructions with and without
// stop pulses and checks every control word against a table
//**********************************************************
module ctrlUnitTb import ctrlPkg::*; ();

    localparam int Timeout = 40;

    logic        clk;
    logic        reset;
    logic        stop;
    logic [31:0] instr;
    logic        run;
    logic        clear;
    ctrlWord_t   ctrl;

    int errorCount = 0;
    int checkCount = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    bit timedOut = 0;

    // Expected step is -1 in the clear step, 0 to 2 in fetch and 3 and up in execute
    int         expStep = -1;
    int         savedStep = 0;
    bit         expHalted = 0;
    logic [4:0] curOp = '0;

    ctrlUnit #(.InstrWidth(32)) DUT (.clk(clk), .reset(reset), .stop(stop),
        .instr(instr), .run(run), .clear(clear), .ctrl(ctrl));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 0 register ALU, 1 unary, 2 immediate, 3 ld, 4 ldi, 5 st, 6 undefined
    function automatic int kindOf(input logic [4:0] op);
        case (op)
            opAdd, opSub, opAnd, opOr, opShl, opShr, opShra, opRol, opRor: return 0;
            opNeg, opNot: return 1;
            opAddi, opAndi, opOri: return 2;
            opLd: return 3;
            opLdi: return 4;
            opSt: return 5;
            default: return 6;
        endcase
    endfunction

    function automatic int execLength(input logic [4:0] op);
        case (kindOf(op))
            3: return 5;
            5: return 4;
            6: return 1;
            default: return 3;
        endcase
    endfunction

    function automatic aluOp_t expectedAluOp(input logic [4:0] op);
        case (op)
            opAdd, opAddi: return aluAdd;
            opSub: return aluSub;
            opAnd, opAndi: return aluAnd;
            opOr, opOri: return aluOr;
            opShr: return aluShr;
            opShra: return aluShra;
            opShl: return aluShl;
            opRor: return aluRor;
            opRol: return aluRol;
            opNeg: return aluNeg;
            opNot: return aluNot;
            default: return aluNop;
        endcase
    endfunction

    // Expected word for step n of an instruction, fetch0 being step 0
    function automatic ctrlWord_t refWord(input logic [4:0] op, input int n);
        ctrlWord_t w;
        int k;
        int e;
        bit mem;
        w = '0;
        k = kindOf(op);
        e = n - 2;
        mem = (k >= 3 && k <= 5);
        if (n == 0) begin
            w.pcOut = 1'b1;
            w.marIn = 1'b1;
            w.zIn = 1'b1;
            w.incPc = 1'b1;
        end else if (n == 1) begin
            w.zLowOut = 1'b1;
            w.pcIn = 1'b1;
            w.read = 1'b1;
            w.mdrIn = 1'b1;
        end else if (n == 2) begin
            w.mdrOut = 1'b1;
            w.irIn = 1'b1;
        end else if (e == 1 && (k <= 2 || mem)) begin
            w.grb = 1'b1;
            w.yIn = 1'b1;
            w.baOut = mem;
        end else if (e == 2 && k <= 2) begin
            w.zIn = 1'b1;
            w.aluOp = expectedAluOp(op);
            w.grc = (k == 0);
            w.rOut = (k == 0);
            w.cOut = (k == 2);
        end else if (e == 2 && mem) begin
            w.zIn = 1'b1;
            w.cOut = 1'b1;
            w.aluOp = aluAdd;
        end else if (e == 3 && (k <= 2 || mem)) begin
            w.zLowOut = 1'b1;
            w.rIn = (k <= 2 || k == 4);
            w.gra = (k <= 2 || k == 4);
            w.marIn = (k == 3 || k == 5);
        end else if (e == 4 && (k == 3 || k == 5)) begin
            w.mdrIn = 1'b1;
            w.read = (k == 3);
            w.write = (k == 5);
            w.rOut = (k == 5);
            w.gra = (k == 5);
        end else if (e == 5 && k == 3) begin
            w.mdrOut = 1'b1;
            w.rIn = 1'b1;
            w.gra = 1'b1;
        end
        return w;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    // Outputs seen here are those of the cycle that is just ending
    always @(posedge clk) begin
        int nextStep;
        if (reset) begin
            compareValue("clear", 32'(clear), 32'd1);
            compareValue("run", 32'(run), 32'd1);
            compareValue("ctrl", 32'(ctrl), 32'd0);
            expStep = -1;
            expHalted = 0;
        end else begin
            compareValue("run", 32'(run), expHalted ? 32'd0 : 32'd1);
            compareValue("clear", 32'(clear), (!expHalted && expStep < 0) ? 32'd1 : 32'd0);
            compareValue("ctrl", 32'(ctrl),
                (expHalted || expStep < 0) ? 32'd0 : 32'(refWord(curOp, expStep)));
            // Decoder takes the opcode at the end of fetch2 even under stop
            if (!expHalted && expStep == 2) begin
                curOp = instr[31:27];
            end
            if (expStep < 0 || expStep >= 2 + execLength(curOp)) begin
                nextStep = 0;
            end else begin
                nextStep = expStep + 1;
            end
            if (stop) begin
                if (!expHalted) begin
                    savedStep = nextStep;
                end
                expHalted = 1;
            end else if (expHalted) begin
                expStep = savedStep;
                expHalted = 0;
            end else begin
                expStep = nextStep;
            end
        end
    end

    task automatic waitFetch0(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(ctrl.pcOut && ctrl.incPc) && cycles < Timeout);
        if (!(ctrl.pcOut && ctrl.incPc)) begin
            $display("Timeout: no fetch step seen within %0d cycles", Timeout);
            timedOut = 1;
            errorCount++;
        end
    endtask

    // Starts in a fetch0 cycle and returns in the next one
    task automatic runInstr(input logic [4:0] op, input int stopAt, input int stopLen);
        int cycles;
        int held;
        held = 0;
        if (!timedOut) begin
            instr = {op, 27'($urandom)};
            if (stopAt >= 0) begin
                repeat (stopAt) @(negedge clk);
                stop = 1'b1;
                repeat (stopLen) @(negedge clk);
                stop = 1'b0;
                held = stopAt + stopLen;
            end
            waitFetch0(cycles);
            if (!timedOut) begin
                compareValue("cycles", 32'(held + cycles),
                    32'(3 + execLength(op) + (stopAt >= 0 ? stopLen : 0)));
            end
        end
    endtask

    task automatic reportTest(input string name, input int mark);
        if (errorCount == mark) begin
            testsPassed++;
            $display("%s: pass", name);
        end else begin
            testsFailed++;
            $display("%s: fail with %0d errors", name, errorCount - mark);
        end
    endtask

    initial begin
        int op;
        int mark;
        int cycles;
        int stopAt;
        logic [4:0] opBits;
        void'($urandom(720));
        reset = 1'b1;
        stop = 1'b0;
        instr = '0;
        mark = errorCount;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        // One clear cycle before fetch0
        waitFetch0(cycles);
        compareValue("cycles", 32'(cycles), 32'd1);
        reportTest("reset and clear step", mark);

        mark = errorCount;
        for (op = 0; op < 32; op++) begin
            if (kindOf(5'(op)) != 6) begin
                runInstr(5'(op), -1, 0);
            end
        end
        reportTest("kept opcodes", mark);

        mark = errorCount;
        runInstr(5'd15, -1, 0);
        runInstr(5'd31, -1, 0);
        reportTest("undefined opcodes", mark);

        mark = errorCount;
        for (op = 0; op < 24; op++) begin
            opBits = 5'($urandom);
            stopAt = $urandom_range(2 + execLength(opBits), 0);
            runInstr(opBits, stopAt, $urandom_range(4, 1));
        end
        reportTest("stop pulses", mark);

        mark = errorCount;
        for (op = 0; op < 200; op++) begin
            opBits = 5'($urandom);
            stopAt = -1;
            if ($urandom_range(2, 0) == 0) begin
                stopAt = $urandom_range(2 + execLength(opBits), 0);
            end
            runInstr(opBits, stopAt, $urandom_range(4, 1));
        end
        reportTest("random mix", mark);

        $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
            testsPassed, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/ctrlUnit.sv ====
//**********************************************************
// Control unit top; connects sequencer, decoder and control
// word table, and passes the instruction width down
//**********************************************************
module ctrlUnit import ctrlPkg::*; #(
    parameter int InstrWidth = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stop,
    input  logic [InstrWidth-1:0] instr,
    output logic                  run,
    output logic                  clear,
    output ctrlWord_t             ctrl
);

    step_t    step;
    decoded_t decoded;

    stepSequencer sequencer (
        .clk    (clk),
        .reset  (reset),
        .stop   (stop),
        .decoded(decoded),
        .step   (step),
        .run    (run),
        .clear  (clear)
    );

    instrDecoder #(
        .InstrWidth(InstrWidth)
    ) decoder (
        .clk    (clk),
        .reset  (reset),
        .step   (step),
        .instr  (instr),
        .decoded(decoded)
    );

    controlWordGen wordGen (
        .step   (step),
        .decoded(decoded),
        .ctrl   (ctrl)
    );

endmodule

// ==== rtl/controlWordGen.sv ====
//**********************************************************
// Control word table; purely combinational from the current
// step and the latched decode
//**********************************************************
module controlWordGen import ctrlPkg::*; (
    input  step_t     step,
    input  decoded_t  decoded,
    output ctrlWord_t ctrl
);

    logic aluClass;
    logic memClass;

    assign aluClass = (decoded.instrClass == clsAluReg) ||
                      (decoded.instrClass == clsAluUnary) ||
                      (decoded.instrClass == clsAluImm);
    assign memClass = (decoded.instrClass == clsLoad) ||
                      (decoded.instrClass == clsLoadImm) ||
                      (decoded.instrClass == clsStore);

    always_comb begin
        ctrl = '0;
        case (step.phase)
            phFetch0: begin
                ctrl.pcOut = 1'b1;
                ctrl.marIn = 1'b1;
                ctrl.zIn = 1'b1;
                ctrl.incPc = 1'b1;
            end
            phFetch1: begin
                ctrl.zLowOut = 1'b1;
                ctrl.pcIn = 1'b1;
                ctrl.read = 1'b1;
                ctrl.mdrIn = 1'b1;
            end
            phFetch2: begin
                ctrl.mdrOut = 1'b1;
                ctrl.irIn = 1'b1;
            end
            phExecute: begin
                if (aluClass) begin
                    case (step.execIndex)
                        3'd1: begin
                            ctrl.grb = 1'b1;
                            ctrl.yIn = 1'b1;
                        end
                        3'd2: begin
                            ctrl.zIn = 1'b1;
                            ctrl.aluOp = decoded.aluOp;
                            // Second operand from rc or from the constant
                            ctrl.grc = (decoded.instrClass == clsAluReg);
                            ctrl.rOut = (decoded.instrClass == clsAluReg);
                            ctrl.cOut = (decoded.instrClass == clsAluImm);
                        end
                        3'd3: begin
                            ctrl.zLowOut = 1'b1;
                            ctrl.gra = 1'b1;
                            ctrl.rIn = 1'b1;
                        end
                        default: ctrl = '0;
                    endcase
                end else if (memClass) begin
                    case (step.execIndex)
                        3'd1: begin
                            ctrl.grb = 1'b1;
                            ctrl.baOut = 1'b1;
                            ctrl.yIn = 1'b1;
                        end
                        3'd2: begin
                            ctrl.zIn = 1'b1;
                            ctrl.cOut = 1'b1;
                            ctrl.aluOp = decoded.aluOp;
                        end
                        3'd3: begin
                            ctrl.zLowOut = 1'b1;
                            // ldi writes the sum back, the others address memory
                            if (decoded.instrClass == clsLoadImm) begin
                                ctrl.rIn = 1'b1;
                                ctrl.gra = 1'b1;
                            end else begin
                                ctrl.marIn = 1'b1;
                            end
                        end
                        3'd4: begin
                            ctrl.mdrIn = 1'b1;
                            ctrl.read = (decoded.instrClass == clsLoad);
                            ctrl.write = (decoded.instrClass == clsStore);
                            ctrl.rOut = (decoded.instrClass == clsStore);
                            ctrl.gra = (decoded.instrClass == clsStore);
                        end
                        3'd5: begin
                            ctrl.mdrOut = 1'b1;
                            ctrl.rIn = 1'b1;
                            ctrl.gra = 1'b1;
                        end
                        default: ctrl = '0;
                    endcase
                end
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== rtl/instrDecoder.sv ====
//**********************************************************
// Instruction decode; sorts the opcode into a class, ALU code
// and execute length, captured while the sequencer is in fetch2
//**********************************************************
module instrDecoder import ctrlPkg::*; #(
    parameter int InstrWidth = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  step_t                 step,
    input  logic [InstrWidth-1:0] instr,
    output decoded_t              decoded
);

    logic [OpcodeWidth-1:0] opcode;
    decoded_t               decodeNext;

    assign opcode = instr[InstrWidth-1 -: OpcodeWidth];

    always_comb begin
        // Undefined opcodes fall through to a single empty step
        decodeNext = '{instrClass: clsNoOp, aluOp: aluNop, execSteps: 3'd1};
        case (irOp_t'(opcode))
            opAdd:  decodeNext = '{clsAluReg, aluAdd, 3'd3};
            opSub:  decodeNext = '{clsAluReg, aluSub, 3'd3};
            opAnd:  decodeNext = '{clsAluReg, aluAnd, 3'd3};
            opOr:   decodeNext = '{clsAluReg, aluOr, 3'd3};
            opShl:  decodeNext = '{clsAluReg, aluShl, 3'd3};
            opShr:  decodeNext = '{clsAluReg, aluShr, 3'd3};
            opShra: decodeNext = '{clsAluReg, aluShra, 3'd3};
            opRol:  decodeNext = '{clsAluReg, aluRol, 3'd3};
            opRor:  decodeNext = '{clsAluReg, aluRor, 3'd3};
            opNeg:  decodeNext = '{clsAluUnary, aluNeg, 3'd3};
            opNot:  decodeNext = '{clsAluUnary, aluNot, 3'd3};
            opAddi: decodeNext = '{clsAluImm, aluAdd, 3'd3};
            opAndi: decodeNext = '{clsAluImm, aluAnd, 3'd3};
            opOri:  decodeNext = '{clsAluImm, aluOr, 3'd3};
            // Memory ops use the ALU for base plus offset
            opLd:   decodeNext = '{clsLoad, aluAdd, 3'd5};
            opLdi:  decodeNext = '{clsLoadImm, aluAdd, 3'd3};
            opSt:   decodeNext = '{clsStore, aluAdd, 3'd4};
            default: begin
                decodeNext = '{instrClass: clsNoOp, aluOp: aluNop, execSteps: 3'd1};
            end
        endcase
    end

    // Held through execute, updated once per instruction
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            decoded <= '{instrClass: clsNoOp, aluOp: aluNop, execSteps: 3'd1};
        end else if (step.phase == phFetch2) begin
            decoded <= decodeNext;
        end
    end

endmodule

// ==== rtl/stepSequencer.sv ====
//**********************************************************
// Step register of the control FSM; one step per clock,
// with stop parking the machine in halt until it is released
//**********************************************************
module stepSequencer import ctrlPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     stop,
    input  decoded_t decoded,
    output step_t    step,
    output logic     run,
    output logic     clear
);

    step_t savedStep;
    step_t successor;

    // Next step in normal order, ignoring stop
    always_comb begin
        successor = '{phase: phFetch0, execIndex: 3'd0};
        case (step.phase)
            phClearing: begin
                successor.phase = phFetch0;
            end
            phFetch0: begin
                successor.phase = phFetch1;
            end
            phFetch1: begin
                successor.phase = phFetch2;
            end
            phFetch2: begin
                // Decoder latches on this same edge, so always start at 1
                successor.phase = phExecute;
                successor.execIndex = 3'd1;
            end
            phExecute: begin
                if (step.execIndex < decoded.execSteps) begin
                    successor.phase = phExecute;
                    successor.execIndex = step.execIndex + 3'd1;
                end
            end
            default: begin
                // Leaving halt resumes where the stop came in
                successor = savedStep;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step <= '{phase: phClearing, execIndex: 3'd0};
            savedStep <= '{phase: phFetch0, execIndex: 3'd0};
        end else if (stop) begin
            step <= '{phase: phHalted, execIndex: 3'd0};
            // Only the first stop cycle records the resume point
            if (step.phase != phHalted) begin
                savedStep <= successor;
            end
        end else begin
            step <= successor;
        end
    end

    assign run = (step.phase != phHalted);
    assign clear = (step.phase == phClearing);

endmodule

// ==== rtl/ctrlPkg.sv ====
//**********************************************************
// Shared types for the CPU control unit: opcodes, ALU codes,
// step and decode records, and the datapath control word
//**********************************************************
package ctrlPkg;

    // Opcode field sits in the top bits of the instruction
    localparam int OpcodeWidth = 5;

    // Instruction opcodes, kept subset of the ISA
    typedef enum logic [OpcodeWidth-1:0] {
        opLd   = 5'b00000,
        opLdi  = 5'b00001,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opShr  = 5'b00111,
        opShra = 5'b01000,
        opShl  = 5'b01001,
        opRor  = 5'b01010,
        opRol  = 5'b01011,
        opAddi = 5'b01100,
        opAndi = 5'b01101,
        opOri  = 5'b01110,
        opNeg  = 5'b10001,
        opNot  = 5'b10010
    } irOp_t;

    // ALU function select seen by the datapath
    typedef enum logic [4:0] {
        aluNop  = 5'd0,
        aluAdd  = 5'd1,
        aluSub  = 5'd2,
        aluShr  = 5'd5,
        aluShl  = 5'd6,
        aluShra = 5'd7,
        aluRor  = 5'd8,
        aluRol  = 5'd9,
        aluAnd  = 5'd10,
        aluOr   = 5'd11,
        aluNeg  = 5'd12,
        aluNot  = 5'd15
    } aluOp_t;

    // Instruction kinds sharing one execute sequence
    typedef enum logic [2:0] {
        clsAluReg,
        clsAluUnary,
        clsAluImm,
        clsLoad,
        clsLoadImm,
        clsStore,
        clsNoOp
    } instrClass_t;

    // Decode latched at the end of fetch
    typedef struct packed {
        instrClass_t instrClass;
        aluOp_t      aluOp;
        logic [2:0]  execSteps;   // 1 to 5
    } decoded_t;

    typedef enum logic [2:0] {
        phClearing,
        phFetch0,
        phFetch1,
        phFetch2,
        phExecute,
        phHalted
    } phase_t;

    // execIndex counts 1 up to execSteps, zero outside execute
    typedef struct packed {
        phase_t     phase;
        logic [2:0] execIndex;
    } step_t;

    // One cycle of datapath strobes
    typedef struct packed {
        logic   read;
        logic   write;
        logic   baOut;
        logic   rIn;
        logic   rOut;
        logic   gra;
        logic   grb;
        logic   grc;
        logic   marIn;
        logic   mdrIn;
        logic   yIn;
        logic   zIn;
        logic   pcIn;
        logic   irIn;
        logic   incPc;
        logic   zLowOut;
        logic   mdrOut;
        logic   cOut;
        logic   pcOut;
        aluOp_t aluOp;
    } ctrlWord_t;

endpackage
